//--- build.f
common/rob_pkg.sv
hdl/result_queue.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
rob/rob.sv
hdl/rob_core_top.sv
sim/tb_rob_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rob core testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/10ps \
  --top-module tb_rob_core \
  --Mdir obj_dir \
  -f build.f

# exit status is nonzero when the testbench stops on a failure
./obj_dir/Vtb_rob_core

//--- sim/tb_rob_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rob_core;

  localparam int credit_timeout = 100;
  localparam int drain_timeout = 400;
  localparam int random_ops = 300;

  logic clk_in;
  logic rst_in;
  logic issue_valid;
  logic [rob_pkg::op_w-1:0] issue_op;
  logic [rob_pkg::data_w-1:0] issue_a;
  logic [rob_pkg::data_w-1:0] issue_b;
  logic [rob_pkg::reg_w-1:0] issue_dest;
  logic issue_credit;
  logic commit_valid;
  logic [rob_pkg::tag_w-1:0] commit_tag;
  logic [rob_pkg::reg_w-1:0] commit_dest;
  logic [rob_pkg::data_w-1:0] commit_value;

  // model entries indexed by tag
  logic [rob_pkg::reg_w-1:0] model_dest [rob_pkg::rob_size];
  logic [rob_pkg::data_w-1:0] model_value [rob_pkg::rob_size];
  int issued_cnt;
  int committed_cnt;
  int outstanding;
  int credits;
  int exp_slot;
  int next_slot;
  logic [rob_pkg::tag_w-1:0] exp_tag;
  logic [rob_pkg::tag_w-1:0] next_tag;
  logic [rob_pkg::reg_w-1:0] exp_dest;
  logic [rob_pkg::data_w-1:0] exp_value;
  // high for the reset cycles and the first one after
  logic rst_seen = 1'b0;
  logic [31:0] rng_state;

  rob_core_top u_rob_core_top (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .issue_valid(issue_valid),
    .issue_op(issue_op),
    .issue_a(issue_a),
    .issue_b(issue_b),
    .issue_dest(issue_dest),
    .issue_credit(issue_credit),
    .commit_valid(commit_valid),
    .commit_tag(commit_tag),
    .commit_dest(commit_dest),
    .commit_value(commit_value)
  );

  always #2 clk_in = ~clk_in;

  // tags count modulo rob_size from 0
  assign exp_slot = committed_cnt % rob_pkg::rob_size;
  assign next_slot = issued_cnt % rob_pkg::rob_size;
  assign exp_tag = exp_slot[rob_pkg::tag_w-1:0];
  assign next_tag = next_slot[rob_pkg::tag_w-1:0];
  assign exp_dest = model_dest[exp_tag];
  assign exp_value = model_value[exp_tag];
  assign credits = rob_pkg::rob_size - outstanding;

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    stop_failed();
  endtask

  task automatic stall_error(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  // expected result straight from the op definitions
  function automatic logic [31:0] ref_result(input logic [rob_pkg::op_w-1:0] op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod;
    logic less;
    prod = {32'b0, a} * {32'b0, b};
    // signs differ, so the negative one is smaller
    less = (a[31] != b[31]) ? a[31] : (a < b);
    case (op)
      rob_pkg::op_add: return a + b;
      rob_pkg::op_sub: return a - b;
      rob_pkg::op_and: return a & b;
      rob_pkg::op_or: return a | b;
      rob_pkg::op_xor: return a ^ b;
      rob_pkg::op_slt: return {31'b0, less};
      rob_pkg::op_mul: return prod[31:0];
      default: return 32'b0;
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // issue bookkeeping and model updates on each edge
  always @(posedge clk_in) begin
    rst_seen <= rst_in;
    if (rst_in) begin
      issued_cnt <= 0;
      committed_cnt <= 0;
      outstanding <= 0;
    end else begin
      if (issue_valid) begin
        model_dest[next_tag] <= issue_dest;
        model_value[next_tag] <= ref_result(issue_op, issue_a, issue_b);
        issued_cnt <= issued_cnt + 1;
      end
      if (commit_valid) begin
        committed_cnt <= committed_cnt + 1;
      end
      // credits come back only through the dut credit port
      outstanding <= outstanding + (issue_valid ? 1 : 0) - (issue_credit ? 1 : 0);
    end
  end

  reset_quiet: assert property (@(posedge clk_in)
      rst_seen |-> !commit_valid && !issue_credit)
    else value_error("commit or credit active around reset");

  credit_match: assert property (@(posedge clk_in) disable iff (rst_in)
      issue_credit == commit_valid)
    else value_error("issue_credit differs from commit_valid");

  credit_range: assert property (@(posedge clk_in) disable iff (rst_in)
      outstanding >= 0 && outstanding <= rob_pkg::rob_size)
    else value_error("credit count left its range");

  no_extra_commit: assert property (@(posedge clk_in) disable iff (rst_in)
      commit_valid |-> committed_cnt < issued_cnt)
    else value_error("commit with nothing in flight");

  alloc_order: assert property (@(posedge clk_in) disable iff (rst_in)
      issue_valid |-> u_rob_core_top.alloc_tag == next_tag)
    else value_error($sformatf("alloc tag %0d, expected %0d",
      $sampled(u_rob_core_top.alloc_tag), $sampled(next_tag)));

  // oldest model entry must retire first
  commit_order: assert property (@(posedge clk_in) disable iff (rst_in)
      commit_valid |-> commit_tag == exp_tag && commit_dest == exp_dest &&
      commit_value == exp_value)
    else value_error($sformatf("commit tag %0d dest %0d value %h, expected %0d %0d %h",
      $sampled(commit_tag), $sampled(commit_dest), $sampled(commit_value),
      $sampled(exp_tag), $sampled(exp_dest), $sampled(exp_value)));

  task automatic next_cycle();
    @(posedge clk_in);
    #1;
  endtask

  task automatic wait_credit();
    int cycles;
    cycles = 0;
    while (credits == 0) begin
      if (cycles >= credit_timeout) begin
        stall_error("timeout: no credit came back while waiting to issue");
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  // model queue empties once every issue has committed
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (committed_cnt != issued_cnt) begin
      if (cycles >= drain_timeout) begin
        stall_error("timeout: operations still in flight after drain limit");
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  // one op on the issue port, held for a single edge
  task automatic send_op(input logic [rob_pkg::op_w-1:0] op, input logic [31:0] a,
                         input logic [31:0] b, input logic [rob_pkg::reg_w-1:0] dest);
    wait_credit();
    issue_valid = 1'b1;
    issue_op = op;
    issue_a = a;
    issue_b = b;
    issue_dest = dest;
    next_cycle();
    issue_valid = 1'b0;
  endtask

  task automatic send_random_op();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [rob_pkg::op_w-1:0] op;
    int gap;
    draw(r);
    draw(a);
    draw(b);
    // code 7 is unused, fold it into mul
    op = (r[2:0] == 3'd7) ? rob_pkg::op_mul : r[2:0];
    // equal operands now and then
    if (r[11:8] == 4'd0) begin
      b = a;
    end
    gap = (r[15:13] < 3'd3) ? int'(r[17:16]) : 0;
    repeat (gap) next_cycle();
    send_op(op, a, b, r[24:20]);
  endtask

  initial begin : main_seq
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [rob_pkg::op_w-1:0] op;
    clk_in = 1'b0;
    rst_in = 1'b1;
    issue_valid = 1'b0;
    issue_op = rob_pkg::op_add;
    issue_a = '0;
    issue_b = '0;
    issue_dest = '0;
    rng_state = 32'he7c9;
    repeat (3) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    next_cycle();

    // mul first, younger alu ops finish ahead of it
    send_op(rob_pkg::op_mul, 32'hffff_fffd, 32'd7, 5'd1);
    send_op(rob_pkg::op_add, 32'd5, 32'd6, 5'd2);
    send_op(rob_pkg::op_sub, 32'd3, 32'd10, 5'd3);
    send_op(rob_pkg::op_and, 32'h0000_f0f0, 32'h0000_ff00, 5'd4);
    wait_drain();
    // slt lands in its queue on the same edge as the mul
    send_op(rob_pkg::op_mul, 32'hffff_ffff, 32'hffff_ffff, 5'd5);
    send_op(rob_pkg::op_or, 32'h1234_0000, 32'h0000_5678, 5'd6);
    send_op(rob_pkg::op_slt, 32'hffff_fffb, 32'd3, 5'd7);
    wait_drain();
    // wrapping product and signed compares
    send_op(rob_pkg::op_mul, 32'h8000_0001, 32'd3, 5'd8);
    send_op(rob_pkg::op_xor, 32'hdead_beef, 32'hffff_0000, 5'd9);
    send_op(rob_pkg::op_slt, 32'd5, 32'hffff_fffb, 5'd10);
    send_op(rob_pkg::op_slt, 32'hffff_fffb, 32'hffff_fffe, 5'd11);
    wait_drain();

    // back-to-back burst from full credits, alternating units
    for (int i = 0; i < rob_pkg::rob_size; i++) begin
      draw(r);
      draw(a);
      draw(b);
      if (i % 2 == 0) begin
        op = rob_pkg::op_mul;
      end else begin
        op = (r[2:1] == 2'b11) ? rob_pkg::op_slt : r[2:0];
      end
      send_op(op, a, b, r[12:8]);
    end
    wait_drain();

    for (int i = 0; i < random_ops; i++) begin
      send_random_op();
    end
    wait_drain();

    if (credits == rob_pkg::rob_size) begin
      $display("TEST OK");
      $finish;
    end else begin
      value_error($sformatf("after drain credits %0d issued %0d committed %0d",
        credits, issued_cnt, committed_cnt));
    end
  end

endmodule

`default_nettype wire

//--- hdl/rob_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rob_core_top (
  input wire clk_in,
  input wire rst_in,
  // issue port
  input wire issue_valid,
  input wire [rob_pkg::op_w-1:0] issue_op,
  input wire [rob_pkg::data_w-1:0] issue_a,
  input wire [rob_pkg::data_w-1:0] issue_b,
  input wire [rob_pkg::reg_w-1:0] issue_dest,
  output logic issue_credit,
  // commit port
  output logic commit_valid,
  output logic [rob_pkg::tag_w-1:0] commit_tag,
  output logic [rob_pkg::reg_w-1:0] commit_dest,
  output logic [rob_pkg::data_w-1:0] commit_value
);

  logic [rob_pkg::tag_w-1:0] alloc_tag;
  logic alu_in_valid;
  logic mul_in_valid;

  // unit queue heads
  logic alu_ready;
  logic [rob_pkg::tag_w-1:0] alu_tag;
  logic [rob_pkg::data_w-1:0] alu_value;
  logic alu_pop;
  logic mul_ready;
  logic [rob_pkg::tag_w-1:0] mul_tag;
  logic [rob_pkg::data_w-1:0] mul_value;
  logic mul_pop;

  // cdb
  logic cdb_valid;
  logic [rob_pkg::tag_w-1:0] cdb_tag;
  logic [rob_pkg::data_w-1:0] cdb_value;

  // steer each issue to exactly one unit
  assign mul_in_valid = issue_valid && rob_pkg::is_mul_op(issue_op);
  assign alu_in_valid = issue_valid && !rob_pkg::is_mul_op(issue_op);

  rob u_rob (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .alloc_valid(issue_valid),
    .alloc_op(issue_op),
    .alloc_dest(issue_dest),
    .alloc_tag(alloc_tag),
    .cdb_valid(cdb_valid),
    .cdb_tag(cdb_tag),
    .cdb_value(cdb_value),
    .commit_valid(commit_valid),
    .commit_tag(commit_tag),
    .commit_dest(commit_dest),
    .commit_value(commit_value),
    .credit(issue_credit)
  );

  alu_unit u_alu_unit (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .in_valid(alu_in_valid),
    .in_op(issue_op),
    .in_a(issue_a),
    .in_b(issue_b),
    .in_tag(alloc_tag),
    .out_valid(alu_ready),
    .out_tag(alu_tag),
    .out_value(alu_value),
    .out_pop(alu_pop)
  );

  mul_unit u_mul_unit (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .in_valid(mul_in_valid),
    .in_a(issue_a),
    .in_b(issue_b),
    .in_tag(alloc_tag),
    .out_valid(mul_ready),
    .out_tag(mul_tag),
    .out_value(mul_value),
    .out_pop(mul_pop)
  );

  cdb_arbiter u_cdb_arbiter (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .alu_ready(alu_ready),
    .alu_tag(alu_tag),
    .alu_value(alu_value),
    .mul_ready(mul_ready),
    .mul_tag(mul_tag),
    .mul_value(mul_value),
    .alu_pop(alu_pop),
    .mul_pop(mul_pop),
    .cdb_valid(cdb_valid),
    .cdb_tag(cdb_tag),
    .cdb_value(cdb_value)
  );

endmodule

`default_nettype wire

//--- rob/rob.sv
`timescale 1ns/10ps
`default_nettype none

module rob (
  input wire clk_in,
  input wire rst_in,
  // allocation from the issue port
  input wire alloc_valid,
  input wire [rob_pkg::op_w-1:0] alloc_op,
  input wire [rob_pkg::reg_w-1:0] alloc_dest,
  output logic [rob_pkg::tag_w-1:0] alloc_tag,
  // writeback from the cdb
  input wire cdb_valid,
  input wire [rob_pkg::tag_w-1:0] cdb_tag,
  input wire [rob_pkg::data_w-1:0] cdb_value,
  // in-order commit
  output logic commit_valid,
  output logic [rob_pkg::tag_w-1:0] commit_tag,
  output logic [rob_pkg::reg_w-1:0] commit_dest,
  output logic [rob_pkg::data_w-1:0] commit_value,
  output logic credit
);

  // pointers carry one wrap bit above the index
  logic [rob_pkg::tag_w:0] head;
  logic [rob_pkg::tag_w:0] tail;
  logic [rob_pkg::tag_w-1:0] head_idx;
  logic [rob_pkg::tag_w-1:0] tail_idx;
  logic not_empty;

  // per-entry storage
  logic [rob_pkg::reg_w-1:0] dest_mem [rob_pkg::rob_size];
  logic [rob_pkg::data_w-1:0] value_mem [rob_pkg::rob_size];
  // set once the cdb has delivered the result
  logic [rob_pkg::rob_size-1:0] ready_bits;

  assign head_idx = head[rob_pkg::tag_w-1:0];
  assign tail_idx = tail[rob_pkg::tag_w-1:0];

  // same index with different wrap bits means full, not empty
  assign not_empty = head != tail;

  // new op gets the slot at the tail
  assign alloc_tag = tail_idx;

  // head retires as soon as its result is in
  assign commit_valid = not_empty && ready_bits[head_idx];
  assign commit_tag = head_idx;
  assign commit_dest = dest_mem[head_idx];
  assign commit_value = value_mem[head_idx];

  // one credit back per retired entry
  assign credit = commit_valid;

  // payload writes
  always_ff @(posedge clk_in) begin
    if (alloc_valid) begin
      dest_mem[tail_idx] <= alloc_dest;
    end
    if (cdb_valid) begin
      value_mem[cdb_tag] <= cdb_value;
    end
  end

  // pointers and ready bits
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head <= '0;
      tail <= '0;
      ready_bits <= '0;
    end else begin
      if (alloc_valid) begin
        // fresh entry waits for its result
        ready_bits[tail_idx] <= 1'b0;
        tail <= tail + 1'b1;
      end
      // cdb never targets the slot being allocated
      // that slot is free, while the cdb tag is in flight
      if (cdb_valid) begin
        ready_bits[cdb_tag] <= 1'b1;
      end
      if (commit_valid) begin
        head <= head + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cdb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
  input wire clk_in,
  input wire rst_in,
  // alu queue head
  input wire alu_ready,
  input wire [rob_pkg::tag_w-1:0] alu_tag,
  input wire [rob_pkg::data_w-1:0] alu_value,
  // mul queue head
  input wire mul_ready,
  input wire [rob_pkg::tag_w-1:0] mul_tag,
  input wire [rob_pkg::data_w-1:0] mul_value,
  output logic alu_pop,
  output logic mul_pop,
  output logic cdb_valid,
  output logic [rob_pkg::tag_w-1:0] cdb_tag,
  output logic [rob_pkg::data_w-1:0] cdb_value
);

  // high when the mul queue won the last grant
  logic last_mul;
  logic grant_alu;
  logic grant_mul;

  // on a tie the side that lost last time goes first
  assign grant_alu = alu_ready && (!mul_ready || last_mul);
  assign grant_mul = mul_ready && !grant_alu;

  assign alu_pop = grant_alu;
  assign mul_pop = grant_mul;

  // one result per cycle
  assign cdb_valid = grant_alu || grant_mul;

  always_comb begin
    if (grant_mul) begin
      cdb_tag = mul_tag;
      cdb_value = mul_value;
    end else begin
      cdb_tag = alu_tag;
      cdb_value = alu_value;
    end
  end

  // only real grants move the priority
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      last_mul <= 1'b0;
    end else if (cdb_valid) begin
      last_mul <= grant_mul;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
  input wire clk_in,
  input wire rst_in,
  input wire in_valid,
  input wire [rob_pkg::data_w-1:0] in_a,
  input wire [rob_pkg::data_w-1:0] in_b,
  input wire [rob_pkg::tag_w-1:0] in_tag,
  output logic out_valid,
  output logic [rob_pkg::tag_w-1:0] out_tag,
  output logic [rob_pkg::data_w-1:0] out_value,
  input wire out_pop
);

  // valid and tag shift alongside the data stages
  logic [rob_pkg::mul_stages-1:0] vld_pipe;
  logic [rob_pkg::tag_w-1:0] tag_pipe [rob_pkg::mul_stages];

  // stage 1 operands
  logic [rob_pkg::data_w-1:0] s1_a;
  logic [rob_pkg::data_w-1:0] s1_b;
  // stage 2 partial products
  // low x low is full width, cross terms only matter in their low half
  logic [31:0] s2_ll;
  logic [15:0] s2_cross;
  // stage 3 low 32 bits of the product
  logic [rob_pkg::data_w-1:0] s3_value;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[rob_pkg::mul_stages-2:0], in_valid};
    end
  end

  always_ff @(posedge clk_in) begin
    tag_pipe[0] <= in_tag;
    for (int i = 1; i < rob_pkg::mul_stages; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
    end
  end

  always_ff @(posedge clk_in) begin
    s1_a <= in_a;
    s1_b <= in_b;
    s2_ll <= {16'b0, s1_a[15:0]} * {16'b0, s1_b[15:0]};
    // hi x hi lands above bit 31 and drops out
    s2_cross <= s1_a[31:16] * s1_b[15:0] + s1_a[15:0] * s1_b[31:16];
    s3_value <= s2_ll + {s2_cross, 16'b0};
  end

  // last stage valid pushes into the queue
  result_queue u_result_queue (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .push(vld_pipe[rob_pkg::mul_stages-1]),
    .push_tag(tag_pipe[rob_pkg::mul_stages-1]),
    .push_value(s3_value),
    .not_empty(out_valid),
    .head_tag(out_tag),
    .head_value(out_value),
    .pop(out_pop)
  );

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
  input wire clk_in,
  input wire rst_in,
  input wire in_valid,
  input wire [rob_pkg::op_w-1:0] in_op,
  input wire [rob_pkg::data_w-1:0] in_a,
  input wire [rob_pkg::data_w-1:0] in_b,
  input wire [rob_pkg::tag_w-1:0] in_tag,
  output logic out_valid,
  output logic [rob_pkg::tag_w-1:0] out_tag,
  output logic [rob_pkg::data_w-1:0] out_value,
  input wire out_pop
);

  logic [rob_pkg::data_w-1:0] result;
  // one registered result ahead of the queue
  logic res_valid;
  logic [rob_pkg::tag_w-1:0] res_tag;
  logic [rob_pkg::data_w-1:0] res_value;

  always_comb begin
    case (in_op)
      rob_pkg::op_add: result = in_a + in_b;
      rob_pkg::op_sub: result = in_a - in_b;
      rob_pkg::op_and: result = in_a & in_b;
      rob_pkg::op_or: result = in_a | in_b;
      rob_pkg::op_xor: result = in_a ^ in_b;
      // signed compare
      rob_pkg::op_slt: result = {{(rob_pkg::data_w-1){1'b0}}, $signed(in_a) < $signed(in_b)};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    res_tag <= in_tag;
    res_value <= result;
  end

  // pushed one edge after the result register
  result_queue u_result_queue (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .push(res_valid),
    .push_tag(res_tag),
    .push_value(res_value),
    .not_empty(out_valid),
    .head_tag(out_tag),
    .head_value(out_value),
    .pop(out_pop)
  );

endmodule

`default_nettype wire

//--- hdl/result_queue.sv
`timescale 1ns/10ps
`default_nettype none

module result_queue (
  input wire clk_in,
  input wire rst_in,
  input wire push,
  input wire [rob_pkg::tag_w-1:0] push_tag,
  input wire [rob_pkg::data_w-1:0] push_value,
  output logic not_empty,
  output logic [rob_pkg::tag_w-1:0] head_tag,
  output logic [rob_pkg::data_w-1:0] head_value,
  input wire pop
);

  // extra msb tells full from empty
  logic [rob_pkg::tag_w:0] wr_ptr;
  logic [rob_pkg::tag_w:0] rd_ptr;

  logic [rob_pkg::tag_w-1:0] tag_mem [rob_pkg::rob_size];
  logic [rob_pkg::data_w-1:0] value_mem [rob_pkg::rob_size];

  assign not_empty = wr_ptr != rd_ptr;

  // head is visible without a read cycle
  assign head_tag = tag_mem[rd_ptr[rob_pkg::tag_w-1:0]];
  assign head_value = value_mem[rd_ptr[rob_pkg::tag_w-1:0]];

  always_ff @(posedge clk_in) begin
    if (push) begin
      tag_mem[wr_ptr[rob_pkg::tag_w-1:0]] <= push_tag;
      value_mem[wr_ptr[rob_pkg::tag_w-1:0]] <= push_value;
    end
  end

  // push and pop may land on the same edge
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

  // reorder buffer depth
  // also the most ops in flight and the depth of each result queue
  localparam int rob_size = 8;
  localparam int tag_w = $clog2(rob_size);

  // datapath widths
  localparam int data_w = 32;
  localparam int reg_w = 5;
  localparam int op_w = 3;

  // op codes
  localparam logic [op_w-1:0] op_add = 3'd0;
  localparam logic [op_w-1:0] op_sub = 3'd1;
  localparam logic [op_w-1:0] op_and = 3'd2;
  localparam logic [op_w-1:0] op_or = 3'd3;
  localparam logic [op_w-1:0] op_xor = 3'd4;
  localparam logic [op_w-1:0] op_slt = 3'd5;
  localparam logic [op_w-1:0] op_mul = 3'd6;

  // multiplier latency in cycles
  localparam int mul_stages = 3;

  // true for ops handled by the multiplier
  function automatic logic is_mul_op(input logic [op_w-1:0] op);
    return op == op_mul;
  endfunction

endpackage

`default_nettype wire
